/* tb.f */
soc_bus_pkg.sv
soc_mem_pkg.sv
wb_interconnect.sv
banked_sram.sv
id_regs.sv
experiar_soc.sv
experiar_soc_assert.sv
tb_experiar_soc.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_experiar_soc
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_experiar_soc.sv */
module tb_experiar_soc;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [10:0] MFR_ID = 11'h456;
	localparam logic [15:0] PART = 16'h0001;
	localparam logic [3:0] VERSION = 4'h1;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst_n;
	soc_bus_pkg::wb_mst_req_t host_req;
	soc_bus_pkg::wb_mst_req_t core_req;
	soc_bus_pkg::wb_rsp_t host_rsp;
	soc_bus_pkg::wb_rsp_t core_rsp;
	soc_bus_pkg::probe_t la_data;

	logic [31:0] seed = 32'hf04bfe5b;
	// Reference contents, core memory at [0], video memory at [1]
	logic [31:0] mem_model [2][1024];
	int checks = 0;
	int errors = 0;
	time first_rsp_time [2];
	time release_time [2];
	int grant_stalls [2];
	int extra_stalls [2];

	experiar_soc #(
		.MANUFACTURER_ID(MFR_ID),
		.PART_ID(PART),
		.VERSION_ID(VERSION)
	) i_experiar_soc (
		.wb_clk_i(clk),
		.rst_n_i(rst_n),
		.host_req_i(host_req),
		.core_req_i(core_req),
		.host_rsp_o(host_rsp),
		.core_rsp_o(core_rsp),
		.la_data_o(la_data)
	);

	bind wb_interconnect experiar_soc_assert i_bus_assert (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.mst_req_i(mst_req_i),
		.mst_rsp_o(mst_rsp_o),
		.owner_q(owner_q)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Region nibble, upper offset bits, bank and word index, byte offset
	function automatic logic [27:0] mk_adr(logic [3:0] region, logic [9:0] idx, logic [11:0] hi);
		return {region, hi, idx, 2'b00};
	endfunction

	function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
			logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				res[i*8 +: 8] = wdata[i*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic soc_bus_pkg::wb_rsp_t rsp_of(int m);
		return (m == 0) ? host_rsp : core_rsp;
	endfunction

	function automatic logic [1:0] owner_of(int s);
		case (s)
			0: return la_data.core_mem_master;
			1: return la_data.video_mem_master;
			default: return la_data.id_regs_master;
		endcase
	endfunction

	function automatic logic [1:0] region_of(int m);
		return (m == 0) ? la_data.host_region : la_data.core_region;
	endfunction

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		errors++;
		$display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic report_failure(string msg);
		errors++;
		$display("Failure at t=%0t: %s", $time, msg);
	endtask

	task automatic timed_out(string what);
		$display("Timeout at t=%0t while waiting for %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic drive(int m, soc_bus_pkg::wb_mst_req_t r);
		if (m == 0) begin
			host_req <= r;
		end else begin
			core_req <= r;
		end
	endtask

	// One access, cyc stays high afterwards unless last is set
	task automatic bus_access(input int m, input logic we, input logic [27:0] adr,
			input logic [3:0] sel, input logic [31:0] wdata, input logic last,
			output logic [31:0] rdata, output logic err, output int stalls);
		soc_bus_pkg::wb_mst_req_t r;
		soc_bus_pkg::wb_rsp_t rsp;
		int waited;
		r = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, data: wdata, adr: adr};
		stalls = 0;
		waited = 0;
		@(posedge clk);
		drive(m, r);
		forever begin
			@(negedge clk);
			rsp = rsp_of(m);
			if (!rsp.stall) break;
			stalls++;
			if (stalls > WAIT_LIMIT) timed_out("stall to fall");
		end
		// Taken at this edge
		@(posedge clk);
		r.stb = 1'b0;
		drive(m, r);
		forever begin
			@(negedge clk);
			rsp = rsp_of(m);
			if (rsp.ack || rsp.error) break;
			waited++;
			if (waited > WAIT_LIMIT) timed_out("ack or error");
		end
		rdata = rsp.data;
		err = rsp.error;
		if (last) begin
			@(posedge clk);
			drive(m, '0);
			release_time[m] = $time;
		end
	endtask

	task automatic bus_write(int m, logic [27:0] adr, logic [3:0] sel, logic [31:0] wdata);
		logic [31:0] rdata;
		logic err;
		int stalls;
		bus_access(m, 1'b1, adr, sel, wdata, 1'b1, rdata, err, stalls);
		checks++;
		if (err) begin
			report_failure("write answered with error");
		end
	endtask

	task automatic bus_read(int m, logic [27:0] adr, logic [31:0] exp, string name);
		logic [31:0] rdata;
		logic err;
		int stalls;
		bus_access(m, 1'b0, adr, 4'hf, 32'h0, 1'b1, rdata, err, stalls);
		checks++;
		if (err) begin
			report_failure("read answered with error");
		end else if (rdata !== exp) begin
			report_mismatch(name, rdata, exp);
		end
	endtask

	// Writes n words from base, then reads them back, all under one cyc
	task automatic run_burst(int m, int r, logic [9:0] base, int n);
		logic [9:0] idx;
		logic [31:0] rdata;
		logic err;
		int stalls;
		extra_stalls[m] = 0;
		for (int i = 0; i < 2 * n; i++) begin
			idx = base + 10'(i % n);
			if (i < n) begin
				mem_model[r][idx] = next_rand();
			end
			bus_access(m, i < n, mk_adr(4'(r), idx, 12'h000), 4'hf, mem_model[r][idx],
				i == 2 * n - 1, rdata, err, stalls);
			if (i == 0) begin
				grant_stalls[m] = stalls;
				first_rsp_time[m] = $time;
			end else begin
				extra_stalls[m] += stalls;
			end
			checks++;
			if (err) begin
				report_failure("burst access answered with error");
			end
			if (i >= n && rdata !== mem_model[r][idx]) begin
				report_mismatch("burst read data", rdata, mem_model[r][idx]);
			end
			// Owner stays visible until cyc drops
			if (i < 2 * n - 1 && owner_of(r) != 2'(m + 1)) begin
				report_mismatch("la_data_o owner", 32'(owner_of(r)), 32'(m + 1));
			end
			if (i < 2 * n - 1 && region_of(m) != 2'(r)) begin
				report_mismatch("la_data_o region", 32'(region_of(m)), 32'(r));
			end
		end
	endtask

	task automatic test_reset();
		soc_bus_pkg::probe_t idle_probe;
		logic [5:0] flags;
		idle_probe = '0;
		idle_probe.host_region = soc_bus_pkg::NONE;
		idle_probe.core_region = soc_bus_pkg::NONE;
		@(negedge clk);
		flags = {host_rsp.ack, host_rsp.stall, host_rsp.error,
			core_rsp.ack, core_rsp.stall, core_rsp.error};
		checks++;
		if (flags !== 6'b0) begin
			report_mismatch("host_rsp_o/core_rsp_o ack stall error", 32'(flags), 32'h0);
		end
		if (la_data !== idle_probe) begin
			report_mismatch("la_data_o", 32'(la_data), 32'(idle_probe));
		end
	endtask

	task automatic test_memories();
		logic [9:0] idx;
		logic [3:0] sel;
		logic [31:0] wdata;
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 6; i++) begin
				idx = 10'(next_rand() >> 7);
				wdata = next_rand();
				bus_write(0, mk_adr(4'(r), idx, 12'h000), 4'hf, wdata);
				mem_model[r][idx] = wdata;
				sel = 4'(next_rand() >> 13);
				wdata = next_rand();
				bus_write(0, mk_adr(4'(r), idx, 12'h000), sel, wdata);
				mem_model[r][idx] = merge_bytes(mem_model[r][idx], wdata, sel);
				bus_read(0, mk_adr(4'(r), idx, 12'h000), mem_model[r][idx], "host read data");
				bus_read(1, mk_adr(4'(r), idx, 12'h000), mem_model[r][idx], "core read data");
				// Offset bits above the bank bit are ignored
				bus_read(1, mk_adr(4'(r), idx, 12'h801), mem_model[r][idx], "aliased read data");
			end
			// Same word index in bank 0 and bank 1
			wdata = next_rand();
			bus_write(0, mk_adr(4'(r), 10'h005, 12'h000), 4'hf, wdata);
			mem_model[r][10'h005] = wdata;
			bus_write(0, mk_adr(4'(r), 10'h205, 12'h000), 4'hf, ~wdata);
			mem_model[r][10'h205] = ~wdata;
			bus_read(0, mk_adr(4'(r), 10'h005, 12'h000), mem_model[r][10'h005], "bank 0 data");
			bus_read(0, mk_adr(4'(r), 10'h205, 12'h000), mem_model[r][10'h205], "bank 1 data");
		end
	endtask

	task automatic test_id_regs();
		logic [31:0] idcode;
		logic [31:0] rdata;
		logic err;
		int stalls;
		idcode = (32'(VERSION) << 28) | (32'(PART) << 12) | (32'(MFR_ID) << 1) | 32'd1;
		bus_read(0, mk_adr(4'd2, 10'd0, 12'h000), idcode, "IDCODE");
		bus_read(1, mk_adr(4'd2, 10'd3, 12'h000), 32'h0, "ID word 3");
		bus_access(0, 1'b1, mk_adr(4'd2, 10'd0, 12'h000), 4'hf, 32'hffff_ffff, 1'b1,
			rdata, err, stalls);
		checks++;
		if (!err) begin
			report_failure("write to the ID block was acked instead of refused");
		end
		bus_read(1, mk_adr(4'd2, 10'd0, 12'h000), idcode, "IDCODE after write");
	endtask

	task automatic test_unmapped();
		logic [31:0] rdata;
		logic err;
		int stalls;
		// Writes land on regions whose low bits alias both memories
		for (int r = 3; r < 16; r++) begin
			bus_access((r >> 1) % 2, 1'(r >> 2), mk_adr(4'(r), 10'h005, 12'h000), 4'hf,
				~mem_model[r % 2][10'h005], 1'b1, rdata, err, stalls);
			checks++;
			if (!err) begin
				report_failure("unmapped access not answered with error");
			end
			if (stalls != 0) begin
				report_mismatch("stall cycles on unmapped access", stalls, 0);
			end
		end
		bus_read(0, mk_adr(4'd0, 10'h005, 12'h000), mem_model[0][10'h005], "core memory word");
		bus_read(0, mk_adr(4'd1, 10'h005, 12'h000), mem_model[1][10'h005], "video memory word");
	endtask

	task automatic test_arbitration();
		// Same slave, the host wins the tie
		fork
			run_burst(0, 0, 10'h100, 4);
			run_burst(1, 0, 10'h140, 4);
		join
		checks++;
		if (first_rsp_time[1] <= release_time[0]) begin
			report_failure("core answered before the host released the slave");
		end
		// Different slaves run side by side
		fork
			run_burst(0, 0, 10'h180, 4);
			run_burst(1, 1, 10'h180, 4);
		join
		for (int m = 0; m < 2; m++) begin
			checks++;
			if (grant_stalls[m] != 1 || extra_stalls[m] != 0) begin
				report_mismatch("stall cycles in burst", grant_stalls[m] + extra_stalls[m], 1);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		host_req = '0;
		core_req = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_memories();
		test_id_regs();
		test_unmapped();
		test_arbitration();
		repeat (2) @(posedge clk);
		errors += i_experiar_soc.i_wb_interconnect.i_bus_assert.failures;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* experiar_soc_assert.sv */
module experiar_soc_assert (
	input logic wb_clk_i,
	input logic rst_n_i,
	input soc_bus_pkg::wb_mst_req_t mst_req_i [soc_bus_pkg::N_MASTERS],
	input soc_bus_pkg::wb_rsp_t mst_rsp_o [soc_bus_pkg::N_MASTERS],
	input logic [soc_bus_pkg::N_SLAVES-1:0][1:0] owner_q
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	// Masters past arbitration toward each slave
	logic [soc_bus_pkg::N_SLAVES-1:0][soc_bus_pkg::N_MASTERS-1:0] passing;

	always_comb begin
		for (int s = 0; s < soc_bus_pkg::N_SLAVES; s++) begin
			for (int m = 0; m < soc_bus_pkg::N_MASTERS; m++) begin
				passing[s][m] = mst_req_i[m].cyc && !mst_rsp_o[m].stall &&
					mst_req_i[m].adr[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB] == 4'(s);
			end
		end
	end

	for (genvar m = 0; m < soc_bus_pkg::N_MASTERS; m++) begin : g_master
		assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
			!(mst_rsp_o[m].ack && mst_rsp_o[m].error))
		else begin
			failures++;
			$error("master %0d sees ack and error together", m);
		end

		// A response needs a strobe taken on the cycle before
		assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
			(mst_rsp_o[m].ack || mst_rsp_o[m].error) |->
			$past(mst_req_i[m].cyc && mst_req_i[m].stb && !mst_rsp_o[m].stall))
		else begin
			failures++;
			$error("master %0d got a response without an accepted strobe", m);
		end

		assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
			mst_req_i[m].cyc && mst_req_i[m].stb && mst_rsp_o[m].stall |=>
			$stable(mst_req_i[m]))
		else begin
			failures++;
			$error("master %0d changed a stalled request", m);
		end
	end

	for (genvar s = 0; s < soc_bus_pkg::N_SLAVES; s++) begin : g_slave
		// At most one unstalled master per slave
		assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
			$countones(passing[s]) <= 1)
		else begin
			failures++;
			$error("slave %0d granted to two masters", s);
		end

		for (genvar m = 0; m < soc_bus_pkg::N_MASTERS; m++) begin : g_lock
			assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
				owner_q[s] == 2'(m + 1) && mst_req_i[m].cyc |=> owner_q[s] == 2'(m + 1))
			else begin
				failures++;
				$error("slave %0d taken from master %0d during its cycle", s, m);
			end
		end
	end

endmodule

/* experiar_soc.sv */
module experiar_soc #(
	parameter logic [10:0] MANUFACTURER_ID = 11'h000,
	parameter logic [15:0] PART_ID = 16'h0000,
	parameter logic [3:0] VERSION_ID = 4'h0,
	parameter int SRAM_ADDR_W = soc_mem_pkg::SRAM_ADDR_W,
	parameter int SRAM_BANKS = soc_mem_pkg::SRAM_BANKS
) (
	input  logic wb_clk_i,
	input  logic rst_n_i,
	input  soc_bus_pkg::wb_mst_req_t host_req_i,
	input  soc_bus_pkg::wb_mst_req_t core_req_i,
	output soc_bus_pkg::wb_rsp_t host_rsp_o,
	output soc_bus_pkg::wb_rsp_t core_rsp_o,
	output soc_bus_pkg::probe_t la_data_o
);

	soc_bus_pkg::wb_mst_req_t mst_req [soc_bus_pkg::N_MASTERS];
	soc_bus_pkg::wb_rsp_t mst_rsp [soc_bus_pkg::N_MASTERS];
	soc_bus_pkg::wb_slv_req_t slv_req [soc_bus_pkg::N_SLAVES];
	soc_bus_pkg::wb_rsp_t slv_rsp [soc_bus_pkg::N_SLAVES];

	// Host sits on slot 0 and wins ties
	assign mst_req[0] = host_req_i;
	assign mst_req[1] = core_req_i;
	assign host_rsp_o = mst_rsp[0];
	assign core_rsp_o = mst_rsp[1];

	wb_interconnect i_wb_interconnect (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.mst_req_i(mst_req),
		.mst_rsp_o(mst_rsp),
		.slv_req_o(slv_req),
		.slv_rsp_i(slv_rsp),
		.probe_o(la_data_o)
	);

	// Core local memory
	banked_sram #(
		.ADDR_W(SRAM_ADDR_W),
		.BANKS(SRAM_BANKS)
	) core_mem (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.req_i(slv_req[soc_bus_pkg::CORE_MEM]),
		.rsp_o(slv_rsp[soc_bus_pkg::CORE_MEM])
	);

	banked_sram #(
		.ADDR_W(SRAM_ADDR_W),
		.BANKS(SRAM_BANKS)
	) video_mem (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.req_i(slv_req[soc_bus_pkg::VIDEO_MEM]),
		.rsp_o(slv_rsp[soc_bus_pkg::VIDEO_MEM])
	);

	id_regs #(
		.MANUFACTURER_ID(MANUFACTURER_ID),
		.PART_ID(PART_ID),
		.VERSION_ID(VERSION_ID)
	) i_id_regs (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.req_i(slv_req[soc_bus_pkg::ID_REGS]),
		.rsp_o(slv_rsp[soc_bus_pkg::ID_REGS])
	);

endmodule

/* id_regs.sv */
module id_regs #(
	parameter logic [10:0] MANUFACTURER_ID = 11'h000,
	parameter logic [15:0] PART_ID = 16'h0000,
	parameter logic [3:0] VERSION_ID = 4'h0
) (
	input  logic wb_clk_i,
	input  logic rst_n_i,
	input  soc_bus_pkg::wb_slv_req_t req_i,
	output soc_bus_pkg::wb_rsp_t rsp_o
);

	// JTAG IDCODE layout, bit 0 is always set
	localparam logic [31:0] IDCODE = {VERSION_ID, PART_ID, MANUFACTURER_ID, 1'b1};

	logic access;
	logic ack_q;
	logic err_q;
	logic [31:0] rdata_q;

	assign access = req_i.cyc && req_i.stb;

	// Read only block, a write gets error
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= access && !req_i.we;
			err_q <= access && req_i.we;
		end
	end

	// Only word 0 holds data
	always_ff @(posedge wb_clk_i) begin
		if (access && !req_i.we) begin
			rdata_q <= (req_i.adr[23:2] == '0) ? IDCODE : '0;
		end
	end

	assign rsp_o = '{ack: ack_q, stall: 1'b0, error: err_q, data: rdata_q};

endmodule

/* banked_sram.sv */
module banked_sram #(
	parameter int ADDR_W = soc_mem_pkg::SRAM_ADDR_W,
	parameter int BANKS = soc_mem_pkg::SRAM_BANKS
) (
	input  logic wb_clk_i,
	input  logic rst_n_i,
	input  soc_bus_pkg::wb_slv_req_t req_i,
	output soc_bus_pkg::wb_rsp_t rsp_o
);

	localparam int DATA_W = soc_mem_pkg::DATA_W;
	localparam int SEL_W = soc_mem_pkg::SEL_W;
	localparam int BYTE_W = DATA_W / SEL_W;
	localparam int DEPTH = 1 << ADDR_W;
	localparam int BANK_W = (BANKS > 1) ? $clog2(BANKS) : 1;

	logic access;
	logic [ADDR_W-1:0] word_idx;
	logic [BANK_W-1:0] bank_sel;
	logic [BANK_W-1:0] bank_q;
	logic [BANKS-1:0] bank_cs;
	logic [BANKS-1:0][DATA_W-1:0] bank_rdata;
	logic ack_q;

	assign access = req_i.cyc && req_i.stb;

	// Byte offset dropped, word index next, bank bits above it
	assign word_idx = req_i.adr[ADDR_W+1:2];
	assign bank_sel = (BANKS > 1) ? req_i.adr[ADDR_W+1+BANK_W:ADDR_W+2] : '0;

	for (genvar b = 0; b < BANKS; b++) begin : g_bank
		logic [DATA_W-1:0] mem [DEPTH];
		logic [DATA_W-1:0] rdata_q;

		assign bank_cs[b] = access && bank_sel == BANK_W'(b);

		// Single read/write port, byte enables from sel
		always_ff @(posedge wb_clk_i) begin
			if (bank_cs[b]) begin
				if (req_i.we) begin
					for (int i = 0; i < SEL_W; i++) begin
						if (req_i.sel[i]) begin
							mem[word_idx][i*BYTE_W +: BYTE_W] <= req_i.data[i*BYTE_W +: BYTE_W];
						end
					end
				end else begin
					rdata_q <= mem[word_idx];
				end
			end
		end

		assign bank_rdata[b] = rdata_q;
	end

	// Every strobe is taken and acked one cycle later
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Remember which bank drives the read word
	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			bank_q <= bank_sel;
		end
	end

	always_comb begin
		rsp_o.ack = ack_q;
		rsp_o.stall = 1'b0;
		rsp_o.error = 1'b0;
		rsp_o.data = bank_rdata[bank_q];
	end

endmodule

/* wb_interconnect.sv */
module wb_interconnect (
	input  logic wb_clk_i,
	input  logic rst_n_i,
	input  soc_bus_pkg::wb_mst_req_t mst_req_i [soc_bus_pkg::N_MASTERS],
	output soc_bus_pkg::wb_rsp_t mst_rsp_o [soc_bus_pkg::N_MASTERS],
	output soc_bus_pkg::wb_slv_req_t slv_req_o [soc_bus_pkg::N_SLAVES],
	input  soc_bus_pkg::wb_rsp_t slv_rsp_i [soc_bus_pkg::N_SLAVES],
	output soc_bus_pkg::probe_t probe_o
);

	localparam int NM = soc_bus_pkg::N_MASTERS;
	localparam int NS = soc_bus_pkg::N_SLAVES;
	localparam int RMSB = soc_bus_pkg::REGION_MSB;
	localparam int RLSB = soc_bus_pkg::REGION_LSB;

	// Master slots, host has priority
	localparam int HOST = 0;
	localparam int CORE = 1;

	// Owner code of master m is m + 1, zero means idle
	localparam int OWN_W = 2;
	localparam logic [OWN_W-1:0] OWN_IDLE = '0;

	soc_bus_pkg::region_e region [NM];
	logic [NM-1:0] mapped;
	logic [NM-1:0] unmapped_err_q;
	logic [NM-1:0] granted;
	logic [NM-1:0] slv_stall;
	logic [NS-1:0] held;
	logic [NS-1:0][OWN_W-1:0] owner_q;
	logic [NS-1:0][OWN_W-1:0] owner_d;

	// Region decode from the top address nibble
	always_comb begin
		for (int m = 0; m < NM; m++) begin
			mapped[m] = mst_req_i[m].adr[RMSB:RLSB] < NS;
			region[m] = mapped[m] ?
				soc_bus_pkg::region_e'(mst_req_i[m].adr[RLSB+1:RLSB]) : soc_bus_pkg::NONE;
		end
	end

	// Ownership is kept while the owner holds cyc
	always_comb begin
		for (int s = 0; s < NS; s++) begin
			held[s] = 1'b0;
			for (int m = 0; m < NM; m++) begin
				if (owner_q[s] == OWN_W'(m + 1) && mst_req_i[m].cyc) begin
					held[s] = 1'b1;
				end
			end
			owner_d[s] = owner_q[s];
			if (!held[s]) begin
				owner_d[s] = OWN_IDLE;
				// Walk down so the lowest index, the host, wins
				for (int m = NM - 1; m >= 0; m--) begin
					if (mst_req_i[m].cyc && region[m] == soc_bus_pkg::region_e'(s)) begin
						owner_d[s] = OWN_W'(m + 1);
					end
				end
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			owner_q <= '0;
			unmapped_err_q <= '0;
		end else begin
			owner_q <= owner_d;
			// Unmapped strobes are answered with error on the next cycle
			for (int m = 0; m < NM; m++) begin
				unmapped_err_q[m] <= mst_req_i[m].cyc && mst_req_i[m].stb && !mapped[m];
			end
		end
	end

	// Requests go to a slave only from its owner
	always_comb begin
		for (int s = 0; s < NS; s++) begin
			slv_req_o[s] = '0;
			for (int m = 0; m < NM; m++) begin
				if (owner_q[s] == OWN_W'(m + 1)) begin
					slv_req_o[s].cyc = mst_req_i[m].cyc;
					slv_req_o[s].stb = mst_req_i[m].cyc && mst_req_i[m].stb &&
						region[m] == soc_bus_pkg::region_e'(s);
					slv_req_o[s].we = mst_req_i[m].we;
					slv_req_o[s].sel = mst_req_i[m].sel;
					slv_req_o[s].data = mst_req_i[m].data;
					slv_req_o[s].adr = mst_req_i[m].adr[RLSB-1:0];
				end
			end
		end
	end

	// Responses come back from every slave the master owns
	always_comb begin
		for (int m = 0; m < NM; m++) begin
			mst_rsp_o[m] = '0;
			granted[m] = 1'b0;
			slv_stall[m] = 1'b0;
			for (int s = 0; s < NS; s++) begin
				if (owner_q[s] == OWN_W'(m + 1)) begin
					mst_rsp_o[m].ack = mst_rsp_o[m].ack | slv_rsp_i[s].ack;
					mst_rsp_o[m].error = mst_rsp_o[m].error | slv_rsp_i[s].error;
					if (slv_rsp_i[s].ack) begin
						mst_rsp_o[m].data = mst_rsp_o[m].data | slv_rsp_i[s].data;
					end
					if (region[m] == soc_bus_pkg::region_e'(s)) begin
						granted[m] = 1'b1;
						slv_stall[m] = slv_rsp_i[s].stall;
					end
				end
			end
			// Stall while waiting for a grant, never on an unmapped region
			mst_rsp_o[m].stall = mst_req_i[m].cyc && mapped[m] &&
				(!granted[m] || slv_stall[m]);
			mst_rsp_o[m].error = mst_rsp_o[m].error | unmapped_err_q[m];
		end
	end

	always_comb begin
		probe_o.host_region = mst_req_i[HOST].cyc ? region[HOST] : soc_bus_pkg::NONE;
		probe_o.core_region = mst_req_i[CORE].cyc ? region[CORE] : soc_bus_pkg::NONE;
		probe_o.core_mem_master = owner_q[soc_bus_pkg::CORE_MEM];
		probe_o.video_mem_master = owner_q[soc_bus_pkg::VIDEO_MEM];
		probe_o.id_regs_master = owner_q[soc_bus_pkg::ID_REGS];
	end

endmodule

/* soc_mem_pkg.sv */
package soc_mem_pkg;

	// Word index width of one bank, 512 words
	localparam int SRAM_ADDR_W = 9;

	// Banks behind one memory slave
	localparam int SRAM_BANKS = 2;

	// Word width of a bank
	localparam int DATA_W = 32;

	// One write enable per byte lane
	localparam int SEL_W = 4;

endpackage

/* soc_bus_pkg.sv */
package soc_bus_pkg;

	// Bus population
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES = 3;

	// Address bits that pick the slave region
	localparam int REGION_MSB = 27;
	localparam int REGION_LSB = 24;

	// Slave index, also the decoded region of a master
	typedef enum logic [1:0] {
		CORE_MEM = 2'd0,
		VIDEO_MEM = 2'd1,
		ID_REGS = 2'd2,
		NONE = 2'd3
	} region_e;

	// Pipelined request as driven by a master
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [31:0] data;
		logic [27:0] adr;
	} wb_mst_req_t;

	// Request seen by a slave, offset inside its region only
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [31:0] data;
		logic [23:0] adr;
	} wb_slv_req_t;

	typedef struct packed {
		logic ack;
		logic stall;
		logic error;
		logic [31:0] data;
	} wb_rsp_t;

	// Logic analyzer word
	// Owner codes are 0 idle, 1 host, 2 core
	typedef struct packed {
		logic [1:0] id_regs_master;
		logic [1:0] video_mem_master;
		logic [1:0] core_mem_master;
		region_e core_region;
		region_e host_region;
	} probe_t;

endpackage
